// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_top
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

SRCS := $(shell cat sim.f)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run check clean

all: check

build: $(BIN)

$(OBJ_DIR)/V%: $(SRCS) sim.f
	$(VERILATOR) $(VFLAGS) -f sim.f --top-module $* -Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)

check: run
	@grep -q "test passed" $(LOG) && ! grep -q "test failed" $(LOG) \
		&& echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== eeprom_cmd_queue.sv ====
`timescale 1ns/100ps
module eeprom_cmd_queue #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                CLK,
    input  logic                RESET,
    input  logic                req_valid,
    input  host_pkg::host_req_t req,
    output logic                credit_return,
    output logic                head_valid,
    output host_pkg::host_req_t head,
    input  logic                take
);
    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    host_pkg::host_req_t mem [QUEUE_DEPTH];
    logic [PTR_W-1:0]    wr_ptr;
    logic [PTR_W-1:0]    rd_ptr;
    logic [CNT_W-1:0]    count;
    logic                full;
    logic                pop;

    assign head_valid = (count != '0);
    assign full       = (count == CNT_W'(QUEUE_DEPTH));
    assign pop        = take && head_valid;
    assign head       = mem[rd_ptr];

    always_ff @(posedge CLK) begin
        if (req_valid)
            mem[wr_ptr] <= req;
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            credit_return <= 1'b0;
        end else begin
            credit_return <= pop; // one credit back per entry leaving
            if (req_valid)
                wr_ptr <= (wr_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            case ({req_valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // host spent a credit it did not hold
    a_no_write_when_full: assert property (@(posedge CLK) disable iff (RESET)
        req_valid |-> !full);

endmodule

// ==== eeprom_ctrl_top.sv ====
`timescale 1ns/100ps
module eeprom_ctrl_top #(
    parameter int CLK_DIV     = 4,
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                CLK,
    input  logic                RESET,
    input  logic                req_valid,
    input  host_pkg::host_req_t req,
    output logic                credit_return,
    output host_pkg::host_rsp_t rsp,
    output logic                scl,
    output logic                sda_drive_low,
    input  logic                sda_in
);
    logic                head_valid;
    host_pkg::host_req_t head;
    logic                take;
    logic                op_start;
    i2c_pkg::bit_op_t    op;
    i2c_pkg::bus_byte_u  op_byte;
    logic                op_busy;
    logic                op_done;
    logic                ack_ok;
    logic [7:0]          rx_byte;

    eeprom_cmd_queue #(
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) queue0 (
        .CLK           (CLK),
        .RESET         (RESET),
        .req_valid     (req_valid),
        .req           (req),
        .credit_return (credit_return),
        .head_valid    (head_valid),
        .head          (head),
        .take          (take)
    );

    eeprom_sequencer seq0 (
        .CLK        (CLK),
        .RESET      (RESET),
        .head_valid (head_valid),
        .head       (head),
        .take       (take),
        .op_start   (op_start),
        .op         (op),
        .op_byte    (op_byte),
        .op_busy    (op_busy),
        .op_done    (op_done),
        .ack_ok     (ack_ok),
        .rx_byte    (rx_byte),
        .rsp        (rsp)
    );

    i2c_bit_engine #(
        .CLK_DIV(CLK_DIV)
    ) bit0 (
        .CLK           (CLK),
        .RESET         (RESET),
        .op_start      (op_start),
        .op            (op),
        .op_byte       (op_byte),
        .op_busy       (op_busy),
        .op_done       (op_done),
        .ack_ok        (ack_ok),
        .rx_byte       (rx_byte),
        .scl           (scl),
        .sda_drive_low (sda_drive_low),
        .sda_in        (sda_in)
    );

endmodule

// ==== eeprom_sequencer.sv ====
`timescale 1ns/100ps
module eeprom_sequencer (
    input  logic                CLK,
    input  logic                RESET,
    input  logic                head_valid,
    input  host_pkg::host_req_t head,
    output logic                take,
    output logic                op_start,
    output i2c_pkg::bit_op_t    op,
    output i2c_pkg::bus_byte_u  op_byte,
    input  logic                op_busy,
    input  logic                op_done,
    input  logic                ack_ok,
    input  logic [7:0]          rx_byte,
    output host_pkg::host_rsp_t rsp
);
    localparam logic [9:0] S_IDLE    = 10'b00_0000_0001;
    localparam logic [9:0] S_START   = 10'b00_0000_0010;
    localparam logic [9:0] S_CTRL_WR = 10'b00_0000_0100;
    localparam logic [9:0] S_ADDR_WR = 10'b00_0000_1000;
    localparam logic [9:0] S_DATA_WR = 10'b00_0001_0000;
    localparam logic [9:0] S_RSTART  = 10'b00_0010_0000;
    localparam logic [9:0] S_CTRL_RD = 10'b00_0100_0000;
    localparam logic [9:0] S_DATA_RD = 10'b00_1000_0000;
    localparam logic [9:0] S_STOP    = 10'b01_0000_0000;
    localparam logic [9:0] S_RESPOND = 10'b10_0000_0000;

    logic [9:0]          state;
    logic                issued;   // op for this state already sent
    logic                bus_state;
    logic                err_q;
    logic [7:0]          rdata_q;
    host_pkg::host_req_t req_q;
    i2c_pkg::bit_op_t    nxt_op;
    i2c_pkg::bus_byte_u  nxt_byte;

    assign take      = (state == S_IDLE) && head_valid;
    assign bus_state = (state != S_IDLE) && (state != S_RESPOND);

    always_comb begin
        nxt_op       = i2c_pkg::OP_WRITE;
        nxt_byte.raw = req_q.wdata;
        case (state)
            S_START, S_RSTART: nxt_op = i2c_pkg::OP_START;
            S_STOP:            nxt_op = i2c_pkg::OP_STOP;
            S_DATA_RD:         nxt_op = i2c_pkg::OP_READ_NACK; // single byte, no ack
            S_ADDR_WR:         nxt_byte.raw = req_q.addr[7:0];
            S_CTRL_WR, S_CTRL_RD: begin
                nxt_byte.ctrl.dev   = i2c_pkg::DEVICE_CODE;
                nxt_byte.ctrl.block = req_q.addr[10:8];
                nxt_byte.ctrl.rd    = (state == S_CTRL_RD);
            end
            default: ;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (take)
            req_q <= head;
        if (bus_state && !issued && !op_busy) begin
            op      <= nxt_op;
            op_byte <= nxt_byte;
        end
        if (take)
            rdata_q <= '0;
        else if (state == S_DATA_RD && op_done)
            rdata_q <= rx_byte;
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state    <= S_IDLE;
            issued   <= 1'b0;
            op_start <= 1'b0;
            err_q    <= 1'b0;
            rsp      <= '0;
        end else begin
            op_start  <= 1'b0;
            rsp.valid <= 1'b0;
            if (bus_state && !issued && !op_busy) begin
                op_start <= 1'b1;
                issued   <= 1'b1;
            end
            if (op_done)
                issued <= 1'b0;

            case (state)
                S_IDLE: begin
                    if (head_valid) begin
                        err_q <= 1'b0;
                        state <= S_START;
                    end
                end
                S_START:  if (op_done) state <= S_CTRL_WR;
                S_RSTART: if (op_done) state <= S_CTRL_RD;
                S_CTRL_WR, S_ADDR_WR, S_CTRL_RD: begin
                    if (op_done && !ack_ok) begin
                        err_q <= 1'b1;
                        state <= S_STOP; // no ack, stop right away
                    end else if (op_done) begin
                        if (state == S_CTRL_RD)
                            state <= S_DATA_RD;
                        else if (state == S_CTRL_WR)
                            state <= S_ADDR_WR;
                        else if (req_q.kind == host_pkg::KIND_WRITE)
                            state <= S_DATA_WR;
                        else
                            state <= S_RSTART;
                    end
                end
                S_DATA_WR: begin
                    if (op_done) begin
                        err_q <= !ack_ok;
                        state <= S_STOP;
                    end
                end
                S_DATA_RD: if (op_done) state <= S_STOP;
                S_STOP:    if (op_done) state <= S_RESPOND;
                S_RESPOND: begin
                    rsp.valid <= 1'b1;
                    rsp.kind  <= req_q.kind;
                    rsp.addr  <= req_q.addr;
                    rsp.rdata <= rdata_q;
                    rsp.err   <= err_q;
                    state     <= S_IDLE;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    a_op_start_not_busy: assert property (@(posedge CLK) disable iff (RESET)
        op_start |-> !op_busy);

endmodule

// ==== host_pkg.sv ====
package host_pkg;

    typedef enum logic {
        KIND_WRITE = 1'b0,
        KIND_READ  = 1'b1
    } op_kind_t;

    // one single-byte request from the host
    typedef struct packed {
        op_kind_t    kind;
        logic [10:0] addr;
        logic [7:0]  wdata;
    } host_req_t;

    // one response per request, in request order
    typedef struct packed {
        logic        valid;
        op_kind_t    kind;
        logic [10:0] addr;
        logic [7:0]  rdata; // zero for writes
        logic        err;   // missing acknowledge
    } host_rsp_t;

endpackage

// ==== i2c_bit_engine.sv ====
`timescale 1ns/100ps
module i2c_bit_engine #(
    parameter int CLK_DIV = 4
) (
    input  logic               CLK,
    input  logic               RESET,
    input  logic               op_start,
    input  i2c_pkg::bit_op_t   op,
    input  i2c_pkg::bus_byte_u op_byte,
    output logic               op_busy,
    output logic               op_done,
    output logic               ack_ok,
    output logic [7:0]         rx_byte,
    output logic               scl,
    output logic               sda_drive_low,
    input  logic               sda_in
);
    localparam int DIV_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;

    i2c_pkg::bit_op_t cur_op;
    logic [DIV_W-1:0] div_cnt;
    logic [4:0]       phase;    // half period index within the op
    logic [7:0]       shreg;
    logic             tick;
    logic             byte_op;
    logic             last_phase;

    assign tick       = (div_cnt == DIV_W'(CLK_DIV - 1));
    assign byte_op    = (cur_op != i2c_pkg::OP_START) && (cur_op != i2c_pkg::OP_STOP);
    assign last_phase = byte_op ? (phase == 5'd17) : (phase == 5'd1);
    assign rx_byte    = shreg;

    // msb out, received bit in at the end of each high half
    always_ff @(posedge CLK) begin
        if (op_start && !op_busy)
            shreg <= op_byte.raw;
        else if (op_busy && tick && byte_op && phase[0] && phase < 5'd16)
            shreg <= {shreg[6:0], sda_in};
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            op_busy       <= 1'b0;
            op_done       <= 1'b0;
            ack_ok        <= 1'b0;
            scl           <= 1'b1;
            sda_drive_low <= 1'b0;
            cur_op        <= i2c_pkg::OP_START;
            div_cnt       <= '0;
            phase         <= '0;
        end else begin
            op_done <= 1'b0;
            if (!op_busy) begin
                if (op_start) begin
                    op_busy <= 1'b1;
                    cur_op  <= op;
                    phase   <= '0;
                    div_cnt <= '0;
                    case (op)
                        i2c_pkg::OP_START: begin
                            scl           <= 1'b1;
                            sda_drive_low <= 1'b0;
                        end
                        i2c_pkg::OP_STOP:  sda_drive_low <= 1'b1; // scl still low
                        i2c_pkg::OP_WRITE: sda_drive_low <= ~op_byte.raw[7];
                        default:           sda_drive_low <= 1'b0;
                    endcase
                end
            end else if (!tick) begin
                div_cnt <= div_cnt + 1'b1;
            end else begin
                div_cnt <= '0;
                phase   <= phase + 1'b1;
                if (last_phase) begin
                    op_busy <= 1'b0;
                    op_done <= 1'b1;
                    if (cur_op == i2c_pkg::OP_STOP)
                        sda_drive_low <= 1'b0; // stop edge, scl high
                    else
                        scl <= 1'b0;
                    if (cur_op == i2c_pkg::OP_WRITE)
                        ack_ok <= ~sda_in;
                end else begin
                    case (cur_op)
                        i2c_pkg::OP_START: sda_drive_low <= 1'b1; // start edge
                        i2c_pkg::OP_STOP:  scl <= 1'b1;
                        default: begin
                            if (!phase[0]) begin
                                scl <= 1'b1;
                            end else begin
                                scl <= 1'b0;
                                if (phase == 5'd15) // ack slot next
                                    sda_drive_low <= (cur_op == i2c_pkg::OP_READ_ACK);
                                else
                                    sda_drive_low <= (cur_op == i2c_pkg::OP_WRITE) && !shreg[6];
                            end
                        end
                    endcase
                end
            end
        end
    end

    a_sda_stable_scl_high: assert property (@(posedge CLK) disable iff (RESET)
        (op_busy && byte_op && scl && $past(scl)) |-> $stable(sda_drive_low));

endmodule

// ==== i2c_pkg.sv ====
package i2c_pkg;

    // operation handed from the sequencer to the bit engine
    typedef enum logic [2:0] {
        OP_START     = 3'd0,
        OP_STOP      = 3'd1,
        OP_WRITE     = 3'd2,
        OP_READ_ACK  = 3'd3,
        OP_READ_NACK = 3'd4
    } bit_op_t;

    // control byte as it goes out on the wire, msb first
    typedef struct packed {
        logic [3:0] dev;   // device type code
        logic [2:0] block; // addr[10:8]
        logic       rd;    // 1 = read
    } ctrl_byte_t;

    // sequencer fills fields, bit engine shifts raw
    typedef union packed {
        ctrl_byte_t ctrl;
        logic [7:0] raw;
    } bus_byte_u;

    localparam logic [3:0] DEVICE_CODE = 4'b1010;

endpackage

// ==== sim.f ====
host_pkg.sv
i2c_pkg.sv
eeprom_cmd_queue.sv
eeprom_sequencer.sv
i2c_bit_engine.sv
eeprom_ctrl_top.sv
tb_clock.sv
tb_eeprom_model.sv
tb_checker.sv
tb_top.sv

// ==== tb_checker.sv ====
`timescale 1ns/100ps
module tb_checker #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                CLK,
    input  logic                RESET,
    input  logic                req_valid,
    input  host_pkg::host_req_t req,
    input  logic                credit_return,
    input  host_pkg::host_rsp_t rsp,
    input  logic [127:0]        test_name,
    output int                  errors,
    output int                  pending,
    output int                  returns
);
    host_pkg::host_req_t expq [$];
    logic [7:0]          shadow [2048];
    logic                written [2048];
    int                  held;

    initial begin
        for (int i = 0; i < 2048; i++)
            written[i] = 1'b0;
    end

    // expected read data from the shadow memory
    function automatic logic [7:0] ref_read(logic [10:0] a);
        if (a[10:8] == 3'd7)
            return 8'h00; // no data phase on a nack
        if (written[a])
            return shadow[a];
        return a[7:0] ^ 8'h5a;
    endfunction

    task automatic compare(string field, logic [31:0] exp_v, logic [31:0] act_v);
        if (exp_v !== act_v) begin
            $display("Mismatch %0s %0s: expected %h actual %h", test_name, field, exp_v, act_v);
            errors++;
        end
    endtask

    always @(posedge CLK) begin
        host_pkg::host_req_t exp_req;
        logic                exp_err;
        if (RESET) begin
            errors  = 0;
            pending = 0;
            returns = 0;
            held    = QUEUE_DEPTH;
        end else begin
            if (req_valid) begin
                expq.push_back(req);
                held--;
            end
            if (credit_return) begin
                returns++;
                held++;
            end
            if (held < 0 || held > QUEUE_DEPTH) begin
                $display("%0s: host credit count out of range (%0d)", test_name, held);
                errors++;
            end
            if (rsp.valid) begin
                if (expq.size() == 0) begin
                    $display("%0s: response arrived with no request outstanding", test_name);
                    errors++;
                end else begin
                    exp_req = expq.pop_front();
                    exp_err = (exp_req.addr[10:8] == 3'd7);
                    compare("kind", 32'(exp_req.kind), 32'(rsp.kind));
                    compare("addr", 32'(exp_req.addr), 32'(rsp.addr));
                    compare("err", 32'(exp_err), 32'(rsp.err));
                    if (exp_req.kind == host_pkg::KIND_READ)
                        compare("rdata", 32'(ref_read(exp_req.addr)), 32'(rsp.rdata));
                    else if (!exp_err) begin
                        shadow[exp_req.addr]  = exp_req.wdata;
                        written[exp_req.addr] = 1'b1;
                    end
                end
            end
            pending = expq.size();
        end
    end
endmodule

// ==== tb_clock.sv ====
`timescale 1ns/100ps
module tb_clock (
    output logic CLK,
    output logic RESET
);
    initial begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK; // 40 ns period
    end

    initial begin
        RESET = 1'b1;
        repeat (2) @(posedge CLK);
        #2 RESET = 1'b0;
    end
endmodule

// ==== tb_eeprom_model.sv ====
`timescale 1ns/100ps
module tb_eeprom_model (
    input  logic CLK,
    input  logic RESET,
    input  logic scl,
    input  logic sda,
    output logic sda_drive_low
);
    localparam int M_IDLE = 0;
    localparam int M_CTRL = 1;
    localparam int M_ADDR = 2;
    localparam int M_WDATA = 3;
    localparam int M_RDATA = 4;

    logic [7:0] mem [2048];
    logic       prev_scl;
    logic       prev_sda;
    logic [7:0] shift;
    logic [7:0] rbyte;
    logic [2:0] block;
    logic [7:0] word;
    logic       rd_req;
    logic       acked;
    int         state;
    int         bit_cnt;
    int         out_cnt;

    initial begin
        for (int i = 0; i < 2048; i++)
            mem[i] = i[7:0] ^ 8'h5a; // initial content
    end

    // line sampled once per CLK, edges seen one cycle late
    always @(posedge CLK) begin
        if (RESET) begin
            prev_scl      <= 1'b1;
            prev_sda      <= 1'b1;
            sda_drive_low <= 1'b0;
            state         <= M_IDLE;
            bit_cnt       <= 0;
            out_cnt       <= 0;
        end else begin
            prev_scl <= scl;
            prev_sda <= sda;
            if (scl && prev_scl && prev_sda && !sda) begin
                state         <= M_CTRL; // start or repeated start
                bit_cnt       <= 0;
                sda_drive_low <= 1'b0;
            end else if (scl && prev_scl && !prev_sda && sda) begin
                state         <= M_IDLE; // stop
                sda_drive_low <= 1'b0;
            end else if (scl && !prev_scl) begin
                if (state != M_IDLE && state != M_RDATA && bit_cnt < 8) begin
                    shift   <= {shift[6:0], sda};
                    bit_cnt <= bit_cnt + 1;
                end
            end else if (!scl && prev_scl) begin
                if (state == M_RDATA) begin
                    if (out_cnt < 8) begin
                        sda_drive_low <= ~rbyte[7 - out_cnt];
                        out_cnt       <= out_cnt + 1;
                    end else begin
                        sda_drive_low <= 1'b0; // master owns the ack slot
                        state         <= M_IDLE;
                    end
                end else if (state != M_IDLE && bit_cnt == 8) begin
                    acked = 1'b1;
                    case (state)
                        M_CTRL: begin
                            // block 7 never answers
                            acked  = (shift[7:4] == 4'b1010) && (shift[3:1] != 3'd7);
                            block <= shift[3:1];
                            rd_req <= shift[0];
                        end
                        M_ADDR:  word <= shift;
                        M_WDATA: mem[{block, word}] <= shift;
                        default: ;
                    endcase
                    sda_drive_low <= acked;
                    bit_cnt       <= acked ? 9 : 0;
                    if (!acked)
                        state <= M_IDLE;
                end else if (state != M_IDLE && bit_cnt == 9) begin
                    sda_drive_low <= 1'b0;
                    bit_cnt       <= 0;
                    case (state)
                        M_CTRL: begin
                            if (rd_req) begin
                                state         <= M_RDATA;
                                rbyte         <= mem[{block, word}];
                                sda_drive_low <= ~mem[{block, word}][7];
                                out_cnt       <= 1;
                            end else begin
                                state <= M_ADDR;
                            end
                        end
                        M_ADDR:  state <= M_WDATA;
                        default: state <= M_IDLE; // single byte writes only
                    endcase
                end
            end
        end
    end
endmodule

// ==== tb_top.sv ====
`timescale 1ns/100ps
module tb_top;
    localparam int CLK_DIV     = 4;
    localparam int QUEUE_DEPTH = 4;
    localparam int WAIT_LIMIT  = 8000; // cycles per wait

    logic                CLK;
    logic                RESET;
    logic                req_valid;
    host_pkg::host_req_t req;
    logic                credit_return;
    host_pkg::host_rsp_t rsp;
    logic                scl;
    logic                dut_sda_low;
    logic                model_sda_low;
    logic                sda_line;
    logic [127:0]        test_name;
    logic [31:0]         seed;
    int                  errors;
    int                  pending;
    int                  returns;
    int                  credits;
    int                  local_errs;
    int                  base_errs;
    int                  tests_run;
    int                  tests_failed;

    assign sda_line = ~(dut_sda_low | model_sda_low); // wired-AND

    tb_clock clk0 (.CLK(CLK), .RESET(RESET));

    eeprom_ctrl_top #(
        .CLK_DIV     (CLK_DIV),
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) dut0 (
        .CLK           (CLK),
        .RESET         (RESET),
        .req_valid     (req_valid),
        .req           (req),
        .credit_return (credit_return),
        .rsp           (rsp),
        .scl           (scl),
        .sda_drive_low (dut_sda_low),
        .sda_in        (sda_line)
    );

    tb_eeprom_model model0 (
        .CLK(CLK), .RESET(RESET), .scl(scl), .sda(sda_line), .sda_drive_low(model_sda_low)
    );

    tb_checker #(.QUEUE_DEPTH(QUEUE_DEPTH)) chk0 (
        .CLK(CLK), .RESET(RESET), .req_valid(req_valid), .req(req),
        .credit_return(credit_return), .rsp(rsp), .test_name(test_name),
        .errors(errors), .pending(pending), .returns(returns)
    );

    always @(posedge CLK) begin
        if (RESET)
            credits <= QUEUE_DEPTH;
        else
            credits <= credits + int'(credit_return) - int'(req_valid);
    end

    function automatic logic [31:0] lcg_next(logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic abort_run(string why);
        $display("%0s: %0s", test_name, why);
        $display("test failed");
        $finish;
    endtask

    // called 2 ns after an edge, returns 2 ns after an edge
    task automatic send_req(host_pkg::op_kind_t kind, logic [10:0] addr, logic [7:0] data);
        int n;
        n = 0;
        while (credits == 0) begin
            @(posedge CLK);
            #2;
            n++;
            if (n > WAIT_LIMIT)
                abort_run("timed out waiting for a credit");
        end
        req_valid  = 1'b1;
        req.kind   = kind;
        req.addr   = addr;
        req.wdata  = data;
        @(posedge CLK);
        #2;
        req_valid = 1'b0;
    endtask

    // responses only, credits are not awaited here
    task automatic collect_responses();
        int n;
        n = 0;
        while (pending != 0) begin
            @(posedge CLK);
            #2;
            n++;
            if (n > WAIT_LIMIT)
                abort_run("timed out waiting for responses");
        end
    endtask

    task automatic wait_drained();
        int n;
        n = 0;
        while (pending != 0 || credits != QUEUE_DEPTH) begin
            @(posedge CLK);
            #2;
            n++;
            if (n > WAIT_LIMIT)
                abort_run("timed out waiting for responses");
        end
    endtask

    task automatic start_test(logic [127:0] name);
        test_name = name;
        base_errs = errors + local_errs;
    endtask

    task automatic finish_test();
        int n;
        wait_drained();
        n = errors + local_errs - base_errs;
        tests_run++;
        if (n == 0) begin
            $display("%0s: ok", test_name);
        end else begin
            $display("%0s: %0d errors", test_name, n);
            tests_failed++;
        end
    endtask

    initial begin
        int n;
        int ret0;
        req_valid    = 1'b0;
        req          = '0;
        seed         = 32'h255489f7;
        test_name    = "reset";
        local_errs   = 0;
        tests_run    = 0;
        tests_failed = 0;
        n = 0;
        while (RESET !== 1'b0) begin
            @(posedge CLK);
            n++;
            if (n > 20)
                abort_run("reset never released");
        end
        @(posedge CLK);
        #2;

        start_test("single_wr_rd");
        send_req(host_pkg::KIND_WRITE, 11'h123, 8'ha5);
        send_req(host_pkg::KIND_READ, 11'h123, 8'h00);
        finish_test();

        start_test("random_40");
        for (int i = 0; i < 40; i++) begin
            seed = lcg_next(seed);
            // few locations so reads hit earlier writes
            send_req(host_pkg::op_kind_t'(seed[24]), {seed[18:16], 4'h0, seed[3:0]}, seed[15:8]);
        end
        finish_test();

        start_test("credit_burst");
        ret0 = returns;
        for (int i = 0; i < QUEUE_DEPTH; i++)
            send_req(host_pkg::KIND_WRITE, 11'h240 + 11'(i), 8'(8'h10 + i));
        collect_responses();
        if (returns - ret0 != QUEUE_DEPTH) begin
            $display("Mismatch %0s credit_returns: expected %0d actual %0d",
                test_name, QUEUE_DEPTH, returns - ret0);
            local_errs++;
        end
        finish_test();

        start_test("rsp_order");
        send_req(host_pkg::KIND_READ, 11'h241, 8'h00);
        send_req(host_pkg::KIND_WRITE, 11'h5c7, 8'h3c);
        send_req(host_pkg::KIND_READ, 11'h0ee, 8'h00);
        send_req(host_pkg::KIND_READ, 11'h5c7, 8'h00);
        send_req(host_pkg::KIND_WRITE, 11'h0ee, 8'hc3);
        send_req(host_pkg::KIND_READ, 11'h0ee, 8'h00);
        finish_test();

        start_test("block7_nack");
        send_req(host_pkg::KIND_WRITE, 11'h033, 8'h77);
        send_req(host_pkg::KIND_WRITE, 11'h733, 8'h99);
        send_req(host_pkg::KIND_READ, 11'h733, 8'h00);
        send_req(host_pkg::KIND_READ, 11'h033, 8'h00);
        finish_test();

        $display("tests run %0d, tests failing %0d, errors %0d",
            tests_run, tests_failed, errors + local_errs);
        if (tests_failed == 0 && errors + local_errs == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end
endmodule
